//--- include/wb_consts.svh
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// result slots carried by one instruction
`define WB_SLOTS 4

// slot payload width
`define WB_DATA_W 64

// eip and memory address width
`define WB_ADDR_W 32

`define WB_RETIRE_DEPTH 4   // packets waiting to commit
`define WB_MEMQ_DEPTH 2     // pending memory writes

`endif

//--- sim/wb_top_tb.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_top_tb;

    typedef logic [`WB_SLOTS-1:0][`WB_DATA_W-1:0] res_vec_t;

    typedef struct packed {
        res_vec_t                             data;
        logic [`WB_SLOTS-1:0][`WB_ADDR_W-1:0] dest;
        logic [`WB_SLOTS-1:0][1:0]            kind;   // 0 none, 1 reg, 2 seg, 3 mem
        logic [`WB_SLOTS-1:0]                 wb;
        logic [1:0]                           op_size;
        logic [3:0]                           ovr;
        logic [`WB_ADDR_W-1:0]                eip;
        logic [`WB_ADDR_W-1:0]                br_target;
        logic                                 br_valid;
        logic                                 br_taken;
        logic                                 br_correct;
        logic [36:0]                          p_op;
        logic                                 ie;
        logic [2:0]                           ie_type;
        logic                                 interrupt;
    } bundle_t;

    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] data;
        logic [1:0]            size;
    } mem_exp_t;

    logic                        clk = 1'b0;
    logic                        rst_n;
    logic                        in_valid, in_ready, mem_ready, mem_valid, valid_out;
    logic                        br_valid, br_taken, br_correct, ie, interrupt;
    logic [`WB_DATA_W-1:0]       in_data [`WB_SLOTS];
    logic [`WB_ADDR_W-1:0]       in_dest [`WB_SLOTS];
    wb_types_pkg::wb_kind_e      in_kind [`WB_SLOTS];
    logic                        in_wb   [`WB_SLOTS];
    logic [1:0]                  op_size, mem_size;
    logic [3:0]                  mem_size_ovr, reg_ld, seg_ld, final_ie_type;
    logic [`WB_ADDR_W-1:0]       eip, br_target, mem_addr, new_eip, eip_hist1, eip_hist2;
    logic [36:0]                 p_op;
    logic [2:0]                  ie_type;
    logic [`WB_DATA_W-1:0]       mem_data;
    logic [`WB_DATA_W-1:0]       res_data [`WB_SLOTS];
    logic [3*`WB_SLOTS-1:0]      wb_addr;
    logic                        br_valid_out, is_resteer, final_ie_val, is_iretd, stall, halts;

    // reference model state
    bundle_t     sent_q[$];   // accepted and waiting for commit
    mem_exp_t    memw_q[$];   // mirrors the write-address queue
    bundle_t     cur_b, head_b;
    mem_exp_t    mhead;
    logic        have_exp, have_mexp, halted_m, saw_stall, saw_block;
    logic [31:0] hist1_m, hist2_m, rng, ready_rng;
    int          mem_pending, ready_mode, held_commits, test_base;
    int          err_count = 0;
    int          sent = 0;
    int          commits = 0;
    int          mem_writes = 0;
    int          cycles = 0;

    logic [7:0]  exp_ld;
    logic [11:0] exp_addr;
    res_vec_t    exp_res, got_res;
    logic [31:0] exp_eip;
    logic [3:0]  exp_flags, exp_ie_type;
    logic        head_mem;

    wb_top uut (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic logic ie_any(input bundle_t b);
        return b.ie | b.interrupt;
    endfunction

    function automatic logic is_far(input bundle_t b);
        return b.p_op[36] | b.p_op[35] | b.p_op[32];
    endfunction

    function automatic logic [3:0] load_mask(input bundle_t b, input logic [1:0] kind);
        logic [3:0] m;
        for (int i = 0; i < `WB_SLOTS; i++)
            m[i] = !ie_any(b) && b.wb[i] && b.kind[i] == kind;
        return m;
    endfunction

    function automatic logic [11:0] dest_pack(input bundle_t b);
        logic [11:0] a;
        for (int i = 0; i < `WB_SLOTS; i++)
            a[3*i +: 3] = b.dest[i][2:0];
        return a;
    endfunction

    function automatic res_vec_t result_data(input bundle_t b);
        res_vec_t r;
        r = b.data;
        if (is_far(b))
            r[0] = {48'd0, b.data[0][47:32]};   // new cs
        return r;
    endfunction

    function automatic logic [31:0] next_eip(input bundle_t b);
        if (is_far(b))
            return b.data[0][31:0];
        return b.br_taken ? b.br_target : b.eip;
    endfunction

    function automatic logic [1:0] write_size(input bundle_t b);
        for (int k = 0; k < 4; k++)
            if (b.ovr[k])
                return 2'(k);
        return is_far(b) ? 2'd3 : b.op_size;
    endfunction

    function automatic int mem_slot(input bundle_t b);
        int s;
        s = -1;
        for (int i = 0; i < `WB_SLOTS; i++)
            if (s < 0 && b.wb[i] && b.kind[i] == 2'd3)
                s = i;
        return s;
    endfunction

    // modes 0 reg/seg, 1 mem, 2 forced mem, 3 branch, 4 exception, 5 far, 6 halt
    function automatic bundle_t make_bundle(input int mode);
        bundle_t b;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            b.data[i] = {next_rand(), next_rand()};
            b.dest[i] = next_rand();
            b.kind[i] = 2'(next_rand());
            b.wb[i]   = 1'(next_rand());
            if (!(mode inside {1, 2, 4, 5}) && b.kind[i] == 2'd3)
                b.kind[i] = 2'd1;
        end
        if (mode == 2) begin
            b.kind[next_rand() % 4] = 2'd3;
            b.wb = 4'hf;
        end
        b.op_size    = 2'(next_rand());
        b.ovr        = (mode == 1 && 1'(next_rand())) ? 4'b1 << 2'(next_rand()) : 4'b0;
        b.eip        = next_rand();
        b.br_target  = next_rand();
        b.br_valid   = 1'(next_rand());
        b.br_taken   = b.br_valid && 1'(next_rand());
        b.br_correct = 1'(next_rand());
        b.p_op       = {5'(next_rand()), next_rand()} & ~37'h19_0000_0600;
        if (mode == 5 || (mode == 1 && next_rand() % 3 == 0)) begin
            case (next_rand() % 3)
                0:       b.p_op[32] = 1'b1;
                1:       b.p_op[35] = 1'b1;
                default: b.p_op[36] = 1'b1;
            endcase
        end
        b.p_op[9]   = (mode == 6);
        b.p_op[10]  = (mode == 4) && 1'(next_rand());
        b.ie        = (mode == 4) && 1'(next_rand());
        b.interrupt = (mode == 4) && 1'(next_rand());
        b.ie_type   = 3'(next_rand());
        return b;
    endfunction

    task automatic drive_bundle(input bundle_t b);
        cur_b = b;
        for (int i = 0; i < `WB_SLOTS; i++) begin
            in_data[i] = b.data[i];
            in_dest[i] = b.dest[i];
            in_kind[i] = wb_types_pkg::wb_kind_e'(b.kind[i]);
            in_wb[i]   = b.wb[i];
        end
        op_size      = b.op_size;
        mem_size_ovr = b.ovr;
        eip          = b.eip;
        br_target    = b.br_target;
        br_valid     = b.br_valid;
        br_taken     = b.br_taken;
        br_correct   = b.br_correct;
        p_op         = b.p_op;
        ie           = b.ie;
        ie_type      = b.ie_type;
        interrupt    = b.interrupt;
    endtask

    // entered and left 2 ns after a rising edge
    task automatic send_bundle(input int mode);
        drive_bundle(make_bundle(mode));
        in_valid = 1'b1;
        while (!in_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while ((sent_q.size() > 0 && !halted_m) || memw_q.size() > 0) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %s done, %0d errors", name, err_count - test_base);
        test_base = err_count;
    endtask

    task automatic report_mismatch(input string name, input logic [255:0] exp,
                                   input logic [255:0] got);
        err_count++;
        $display("Fail %s exp %0h got %0h at %0t", name, exp, got, $time);
    endtask

    task automatic report_error(input string what);
        err_count++;
        $display("%s at %0t", what, $time);
    endtask

    assign exp_ld      = {load_mask(head_b, 2'd1), load_mask(head_b, 2'd2)};
    assign exp_addr    = dest_pack(head_b);
    assign exp_res     = result_data(head_b);
    assign exp_eip     = next_eip(head_b);
    assign exp_ie_type = {head_b.interrupt, head_b.ie_type};
    assign head_mem    = have_exp && mem_slot(head_b) >= 0;
    assign exp_flags   = {valid_out && head_b.br_valid,
                          valid_out && head_b.br_valid && !head_b.br_correct,
                          valid_out && ie_any(head_b),
                          valid_out && head_b.p_op[10]};

    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++)
            got_res[i] = res_data[i];
    end

    // mem_ready pattern from a second generator
    always @(posedge clk) begin
        #2;
        ready_rng = xorshift32(ready_rng);
        case (ready_mode)
            0:       mem_ready = 1'b1;
            1:       mem_ready = ready_rng[0];
            default: mem_ready = 1'b0;
        endcase
    end

    always @(posedge clk) begin
        mem_exp_t w;
        bundle_t  cb;
        int       s;
        if (!rst_n) begin
            sent_q.delete();
            memw_q.delete();
            halted_m = 1'b0;
            hist1_m  = '0;
            hist2_m  = '0;
        end else begin
            if (mem_valid && mem_ready && memw_q.size() > 0) begin
                w = memw_q.pop_front();
                mem_writes++;
            end
            if (valid_out && sent_q.size() > 0) begin
                cb = sent_q.pop_front();
                commits++;
                hist2_m = hist1_m;
                hist1_m = cb.eip;
                if (cb.p_op[9])
                    halted_m = 1'b1;
                s = mem_slot(cb);
                if (!ie_any(cb) && s >= 0) begin
                    w.addr = cb.dest[s];
                    w.data = cb.data[s];
                    w.size = write_size(cb);
                    memw_q.push_back(w);
                end
            end
            if (in_valid && in_ready) begin
                sent_q.push_back(cur_b);
                sent++;
            end
            if (stall)
                saw_stall = 1'b1;
            if (!in_ready)
                saw_block = 1'b1;
        end
        have_exp  = sent_q.size() > 0;
        have_mexp = memw_q.size() > 0;
        if (have_exp)
            head_b = sent_q[0];
        if (have_mexp)
            mhead = memw_q[0];
        mem_pending = memw_q.size();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * sent + 200) begin
            $display("timeout after %0d cycles with %0d bundles sent", cycles, sent);
            $display("Simulation FAILED");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> have_exp && !halted_m)
        else report_error("commit with no packet outstanding or after a halt");
    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> {reg_ld, seg_ld} == exp_ld)
        else report_mismatch("{reg_ld,seg_ld}", $sampled(exp_ld), $sampled({reg_ld, seg_ld}));
    assert property (@(posedge clk) disable iff (!rst_n) !valid_out |-> {reg_ld, seg_ld} == '0)
        else report_mismatch("{reg_ld,seg_ld}", 0, $sampled({reg_ld, seg_ld}));
    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> wb_addr == exp_addr)
        else report_mismatch("wb_addr", $sampled(exp_addr), $sampled(wb_addr));
    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> got_res == exp_res)
        else report_mismatch("res_data", $sampled(exp_res), $sampled(got_res));
    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> new_eip == exp_eip)
        else report_mismatch("new_eip", $sampled(exp_eip), $sampled(new_eip));
    assert property (@(posedge clk) disable iff (!rst_n)
                     {br_valid_out, is_resteer, final_ie_val, is_iretd} == exp_flags)
        else report_mismatch("{br_valid_out,is_resteer,final_ie_val,is_iretd}",
                             $sampled(exp_flags),
                             $sampled({br_valid_out, is_resteer, final_ie_val, is_iretd}));
    assert property (@(posedge clk) disable iff (!rst_n) valid_out |-> final_ie_type == exp_ie_type)
        else report_mismatch("final_ie_type", $sampled(exp_ie_type), $sampled(final_ie_type));
    assert property (@(posedge clk) disable iff (!rst_n)
                     stall |-> !valid_out && head_mem && mem_pending == `WB_MEMQ_DEPTH)
        else report_error("stall high without a full write queue, or with a commit");
    assert property (@(posedge clk) disable iff (!rst_n) halts == halted_m)
        else report_mismatch("halts", $sampled(halted_m), $sampled(halts));
    assert property (@(posedge clk) disable iff (!rst_n)
                     {eip_hist1, eip_hist2} == {hist1_m, hist2_m})
        else report_mismatch("{eip_hist1,eip_hist2}", $sampled({hist1_m, hist2_m}),
                             $sampled({eip_hist1, eip_hist2}));
    assert property (@(posedge clk) disable iff (!rst_n) mem_valid == have_mexp)
        else report_mismatch("mem_valid", $sampled(have_mexp), $sampled(mem_valid));
    assert property (@(posedge clk) disable iff (!rst_n)
                     mem_valid && mem_ready |-> {mem_addr, mem_data, mem_size} == mhead)
        else report_mismatch("{mem_addr,mem_data,mem_size}", $sampled(mhead),
                             $sampled({mem_addr, mem_data, mem_size}));

    initial begin
        rng        = 32'd63607;
        ready_rng  = 32'd63607;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        mem_ready  = 1'b1;
        ready_mode = 0;
        test_base  = 0;
        drive_bundle('0);
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;

        repeat (12) send_bundle(0);
        wait_drain();
        finish_test("reg_seg_writes");

        ready_mode = 1;   // random memory port stalls
        repeat (16) send_bundle(1);
        wait_drain();
        ready_mode = 0;
        finish_test("memory_writes");

        ready_mode = 2;
        saw_stall  = 1'b0;
        saw_block  = 1'b0;
        fork
            repeat (10) send_bundle(2);
            begin
                repeat (30) @(posedge clk);
                #1;
                held_commits = commits;
                repeat (10) @(posedge clk);
                #1;
                assert (saw_stall)
                    else report_error("back-pressure: stall never rose with mem_ready low");
                assert (saw_block)
                    else report_error("back-pressure: in_ready never fell with mem_ready low");
                assert (commits == held_commits)
                    else report_error("back-pressure: packets committed into a full queue");
                ready_mode = 0;
            end
        join
        wait_drain();
        finish_test("back_pressure");

        repeat (12) send_bundle(3);
        wait_drain();
        finish_test("branches");

        repeat (16) send_bundle(4);
        wait_drain();
        finish_test("exceptions");

        repeat (4) send_bundle(5);
        send_bundle(6);
        repeat (3) send_bundle(0);   // stuck behind the halt
        wait_drain();
        repeat (20) @(posedge clk);
        #2;
        assert (halted_m && sent_q.size() == 3)
            else report_error("halt: later packets did not stay behind the halt packet");
        finish_test("far_history_halt");

        $display("summary: %0d sent, %0d committed, %0d memory writes, %0d errors",
                 sent, commits, mem_writes, err_count);
        if (err_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src/wb_fifo.sv
`timescale 1ns/1ps

module wb_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     pop_data,
    output logic empty,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;
    assign do_pop   = pop && !empty;   // empty blocks pop even on a push
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push+pop
            endcase
        end
    end

endmodule

//--- src/wb_packet_if.sv
`timescale 1ns/1ps

interface wb_packet_if;

    logic                    valid;
    logic                    ready;
    wb_types_pkg::wb_packet_t pkt;

    // pkt must hold while valid && !ready
    modport source (
        output valid,
        output pkt,
        input  ready
    );

    modport sink (
        input  valid,
        input  pkt,
        output ready
    );

endinterface

//--- src/wb_result_packer.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_result_packer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`WB_DATA_W-1:0]    in_data [`WB_SLOTS],
    input  logic [`WB_ADDR_W-1:0]    in_dest [`WB_SLOTS],
    input  wb_types_pkg::wb_kind_e   in_kind [`WB_SLOTS],
    input  logic                     in_wb   [`WB_SLOTS],
    input  logic [1:0]               op_size,
    input  logic [3:0]               mem_size_ovr,
    input  logic [`WB_ADDR_W-1:0]    eip,
    input  logic [`WB_ADDR_W-1:0]    br_target,
    input  logic                     br_valid,
    input  logic                     br_taken,
    input  logic                     br_correct,
    input  logic [36:0]              p_op,
    input  logic                     ie,
    input  logic [2:0]               ie_type,
    input  logic                     interrupt,
    wb_packet_if.source              out
);

    logic                     far_xfer;
    logic [1:0]               mem_size;
    logic                     accept;
    wb_types_pkg::wb_packet_t pkt_d;

    // far jmp / far call / ret far
    assign far_xfer = p_op[36] | p_op[35] | p_op[32];

    always_comb begin
        if (mem_size_ovr[0])      mem_size = 2'd0;
        else if (mem_size_ovr[1]) mem_size = 2'd1;
        else if (mem_size_ovr[2]) mem_size = 2'd2;
        else if (mem_size_ovr[3]) mem_size = 2'd3;
        else if (far_xfer)        mem_size = 2'd3;   // cs:eip pair
        else                      mem_size = op_size;
    end

    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            pkt_d.slots[i].data = in_data[i];
            pkt_d.slots[i].dest = in_dest[i];
            pkt_d.slots[i].kind = in_kind[i];
            pkt_d.slots[i].wb   = in_wb[i];
        end
        pkt_d.op_size    = op_size;
        pkt_d.mem_size   = mem_size;
        pkt_d.eip        = eip;
        pkt_d.br_target  = br_target;
        pkt_d.br_valid   = br_valid;
        pkt_d.br_taken   = br_taken;
        pkt_d.br_correct = br_correct;
        pkt_d.far_xfer   = far_xfer;
        pkt_d.halt       = p_op[9];
        pkt_d.iretd      = p_op[10];
        pkt_d.ie         = ie;
        pkt_d.ie_type    = ie_type;
        pkt_d.interrupt  = interrupt;
    end

    // slot empty or draining this cycle
    assign in_ready = rst_n && (!out.valid || out.ready);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out.valid <= 1'b0;
        end else begin
            if (accept)
                out.valid <= 1'b1;
            else if (out.ready)
                out.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            out.pkt <= pkt_d;
    end

endmodule

//--- src/wb_stage.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_stage (
    input  logic                         clk,
    input  logic                         rst_n,
    wb_packet_if.sink                    in,
    output logic                         memq_push,
    output wb_types_pkg::wb_mem_write_t  memq_data,
    input  logic                         memq_full,
    output logic                         valid_out,
    output logic [`WB_DATA_W-1:0]        res_data [`WB_SLOTS],
    output logic [`WB_SLOTS-1:0]         reg_ld,
    output logic [`WB_SLOTS-1:0]         seg_ld,
    output logic [3*`WB_SLOTS-1:0]       wb_addr,
    output logic [`WB_ADDR_W-1:0]        new_eip,
    output logic                         br_valid_out,
    output logic                         is_resteer,
    output logic                         final_ie_val,
    output logic [3:0]                   final_ie_type,
    output logic                         is_iretd,
    output logic                         stall,
    output logic                         halts,
    output logic [`WB_ADDR_W-1:0]        eip_hist1,
    output logic [`WB_ADDR_W-1:0]        eip_hist2
);

    wb_types_pkg::wb_packet_t pkt;
    logic                     halted;
    logic                     ie_any;
    logic                     wr_en;     // commit without exception
    logic                     mem_any;
    logic [`WB_ADDR_W-1:0]    target;

    assign pkt    = in.pkt;
    assign ie_any = pkt.ie | pkt.interrupt;

    // lowest memory slot wins, so scan from the top down
    always_comb begin
        mem_any   = 1'b0;
        memq_data = '0;
        for (int i = `WB_SLOTS - 1; i >= 0; i--) begin
            if (pkt.slots[i].wb && pkt.slots[i].kind == wb_types_pkg::WB_KIND_MEM) begin
                mem_any        = 1'b1;
                memq_data.addr = pkt.slots[i].dest;
                memq_data.data = pkt.slots[i].data;
            end
        end
        memq_data.size = pkt.mem_size;
    end

    assign stall     = in.valid && mem_any && memq_full;
    assign valid_out = in.valid && !halted && !stall;
    assign in.ready  = valid_out;   // pop the head on commit
    assign wr_en     = valid_out && !ie_any;
    assign memq_push = wr_en && mem_any;

    always_comb begin
        for (int i = 0; i < `WB_SLOTS; i++) begin
            reg_ld[i] = wr_en && pkt.slots[i].wb &&
                        pkt.slots[i].kind == wb_types_pkg::WB_KIND_REG;
            seg_ld[i] = wr_en && pkt.slots[i].wb &&
                        pkt.slots[i].kind == wb_types_pkg::WB_KIND_SEG;
            wb_addr[3*i +: 3] = pkt.slots[i].dest[2:0];
            res_data[i]       = pkt.slots[i].data;
        end
        // far transfer loads the new cs from slot 0
        if (pkt.far_xfer)
            res_data[0] = {{(`WB_DATA_W - 16){1'b0}}, pkt.slots[0].data[47:32]};
    end

    assign target  = pkt.far_xfer ? pkt.slots[0].data[`WB_ADDR_W-1:0] : pkt.br_target;
    assign new_eip = (pkt.br_taken || pkt.far_xfer) ? target : pkt.eip;

    assign br_valid_out = valid_out && pkt.br_valid;
    assign is_resteer   = valid_out && pkt.br_valid && !pkt.br_correct;   // mispredict

    assign final_ie_val  = valid_out && ie_any;
    assign final_ie_type = valid_out ? {pkt.interrupt, pkt.ie_type} : 4'd0;
    assign is_iretd      = valid_out && pkt.iretd;

    assign halts = halted;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halted    <= 1'b0;
            eip_hist1 <= '0;
            eip_hist2 <= '0;
        end else if (valid_out) begin
            if (pkt.halt)
                halted <= 1'b1;   // sticky until reset
            eip_hist1 <= pkt.eip;
            eip_hist2 <= eip_hist1;
        end
    end

endmodule

//--- src/wb_top.sv
`timescale 1ns/1ps

`include "wb_consts.svh"

module wb_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic [`WB_DATA_W-1:0]    in_data [`WB_SLOTS],
    input  logic [`WB_ADDR_W-1:0]    in_dest [`WB_SLOTS],
    input  wb_types_pkg::wb_kind_e   in_kind [`WB_SLOTS],
    input  logic                     in_wb   [`WB_SLOTS],
    input  logic [1:0]               op_size,
    input  logic [3:0]               mem_size_ovr,
    input  logic [`WB_ADDR_W-1:0]    eip,
    input  logic [`WB_ADDR_W-1:0]    br_target,
    input  logic                     br_valid,
    input  logic                     br_taken,
    input  logic                     br_correct,
    input  logic [36:0]              p_op,
    input  logic                     ie,
    input  logic [2:0]               ie_type,
    input  logic                     interrupt,
    output logic                     mem_valid,
    output logic [`WB_ADDR_W-1:0]    mem_addr,
    output logic [`WB_DATA_W-1:0]    mem_data,
    output logic [1:0]               mem_size,
    input  logic                     mem_ready,
    output logic                     valid_out,
    output logic [`WB_DATA_W-1:0]    res_data [`WB_SLOTS],
    output logic [`WB_SLOTS-1:0]     reg_ld,
    output logic [`WB_SLOTS-1:0]     seg_ld,
    output logic [3*`WB_SLOTS-1:0]   wb_addr,
    output logic [`WB_ADDR_W-1:0]    new_eip,
    output logic                     br_valid_out,
    output logic                     is_resteer,
    output logic                     final_ie_val,
    output logic [3:0]               final_ie_type,
    output logic                     is_iretd,
    output logic                     stall,
    output logic                     halts,
    output logic [`WB_ADDR_W-1:0]    eip_hist1,
    output logic [`WB_ADDR_W-1:0]    eip_hist2
);

    wb_packet_if pk_if ();   // packer to retire queue
    wb_packet_if rq_if ();   // retire queue head to stage

    logic                        rq_empty;
    logic                        rq_full;
    logic                        memq_push;
    logic                        memq_full;
    logic                        memq_empty;
    wb_types_pkg::wb_mem_write_t memq_data;
    wb_types_pkg::wb_mem_write_t memq_head;

    wb_result_packer u_packer (
        .clk, .rst_n, .in_valid, .in_ready, .in_data, .in_dest, .in_kind, .in_wb,
        .op_size, .mem_size_ovr, .eip, .br_target, .br_valid, .br_taken,
        .br_correct, .p_op, .ie, .ie_type, .interrupt,
        .out (pk_if.source)
    );

    assign pk_if.ready = !rq_full;
    assign rq_if.valid = !rq_empty;

    wb_fifo #(.T(wb_types_pkg::wb_packet_t), .DEPTH(`WB_RETIRE_DEPTH)) u_retire_q (
        .clk, .rst_n,
        .push (pk_if.valid), .push_data (pk_if.pkt),
        .pop (rq_if.ready), .pop_data (rq_if.pkt),
        .empty (rq_empty), .full (rq_full)
    );

    wb_stage u_stage (
        .clk, .rst_n,
        .in (rq_if.sink),
        .memq_push, .memq_data, .memq_full,
        .valid_out, .res_data, .reg_ld, .seg_ld, .wb_addr, .new_eip, .br_valid_out,
        .is_resteer, .final_ie_val, .final_ie_type, .is_iretd, .stall, .halts,
        .eip_hist1, .eip_hist2
    );

    wb_fifo #(.T(wb_types_pkg::wb_mem_write_t), .DEPTH(`WB_MEMQ_DEPTH)) u_memq (
        .clk, .rst_n,
        .push (memq_push), .push_data (memq_data),
        .pop (mem_ready), .pop_data (memq_head),
        .empty (memq_empty), .full (memq_full)
    );

    // queue head drives the memory port
    assign mem_valid = !memq_empty;
    assign mem_addr  = memq_head.addr;
    assign mem_data  = memq_head.data;
    assign mem_size  = memq_head.size;

endmodule

//--- src/wb_types_pkg.sv
package wb_types_pkg;

    `include "wb_consts.svh"

    // destination class of one slot
    typedef enum logic [1:0] {
        WB_KIND_NONE = 2'd0,
        WB_KIND_REG  = 2'd1,
        WB_KIND_SEG  = 2'd2,
        WB_KIND_MEM  = 2'd3
    } wb_kind_e;

    typedef struct packed {
        logic [`WB_DATA_W-1:0] data;
        logic [`WB_ADDR_W-1:0] dest;   // low 3 bits for reg/seg
        wb_kind_e              kind;
        logic                  wb;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [`WB_SLOTS-1:0] slots;
        logic [1:0]               op_size;
        logic [1:0]               mem_size;   // override/far/op already applied
        logic [`WB_ADDR_W-1:0]    eip;
        logic [`WB_ADDR_W-1:0]    br_target;
        logic                     br_valid;
        logic                     br_taken;
        logic                     br_correct;
        logic                     far_xfer;
        logic                     halt;
        logic                     iretd;
        logic                     ie;
        logic [2:0]               ie_type;
        logic                     interrupt;
    } wb_packet_t;

    // one entry of the write-address queue
    typedef struct packed {
        logic [`WB_ADDR_W-1:0] addr;
        logic [`WB_DATA_W-1:0] data;
        logic [1:0]            size;
    } wb_mem_write_t;

endpackage

//--- wb.f
+incdir+include
src/wb_types_pkg.sv
src/wb_packet_if.sv
src/wb_result_packer.sv
src/wb_fifo.sv
src/wb_stage.sv
src/wb_top.sv
sim/wb_top_tb.sv
